/* verilog.f */
+incdir+.
pcie_dma_ctrl_pkg.sv
dma_desc_regs.sv
tlp_counters.sv
ctrl_reg_bus.sv
pcie_dma_ctrl_top.sv
pcie_dma_ctrl_assertions.sv
tb_clk_gen.sv
tb_pcie_dma_ctrl.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pcie_dma_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_pcie_dma_ctrl.sv */
// testbench top with bus tasks, reference model and read-data comparison
`timescale 1ns/1ps
`include "pcie_dma_ctrl_consts.svh"

module tb_pcie_dma_ctrl;
    import pcie_dma_ctrl_pkg::*;

    localparam int TIMEOUT = 50;
    localparam reg_addr_t REG_LIST [17] = '{
        `REG_ENABLE,
        `REG_RD_PCIE_LO, `REG_RD_PCIE_HI, `REG_RD_AXI, `REG_RD_LEN, `REG_RD_TAG, `REG_RD_STATUS,
        `REG_WR_PCIE_LO, `REG_WR_PCIE_HI, `REG_WR_AXI, `REG_WR_LEN, `REG_WR_TAG, `REG_WR_STATUS,
        `REG_CNT_RQ, `REG_CNT_RC, `REG_CNT_CQ, `REG_CNT_CC
    };

    logic        clk;
    logic        rst;
    logic        wr_valid;
    reg_addr_t   wr_addr;
    reg_data_t   wr_data;
    logic        wr_ack;
    logic        rd_valid;
    reg_addr_t   rd_addr;
    reg_data_t   rd_data;
    logic        rd_ack;
    dma_desc_t   rd_desc;
    logic        rd_desc_valid;
    logic        rd_desc_ready;
    dma_desc_t   wr_desc;
    logic        wr_desc_valid;
    logic        wr_desc_ready;
    dma_status_t rd_status;
    logic        rd_status_valid;
    dma_status_t wr_status;
    logic        wr_status_valid;
    stream_tap_t rq_tap;
    stream_tap_t rc_tap;
    stream_tap_t cq_tap;
    stream_tap_t cc_tap;
    logic        dma_enable;
    logic        irq;

    // model state
    logic        enable_m;
    dma_status_t status_m [2];
    logic [1:0]  status_valid_m;
    pkt_count_t  count_m [4];

    reg_data_t   exp_q [$];
    reg_addr_t   addr_q [$];
    logic [31:0] rng;
    int          err_count;

    tb_clk_gen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    pcie_dma_ctrl_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .wr_valid        (wr_valid),
        .wr_addr         (wr_addr),
        .wr_data         (wr_data),
        .wr_ack          (wr_ack),
        .rd_valid        (rd_valid),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .rd_ack          (rd_ack),
        .rd_desc         (rd_desc),
        .rd_desc_valid   (rd_desc_valid),
        .rd_desc_ready   (rd_desc_ready),
        .wr_desc         (wr_desc),
        .wr_desc_valid   (wr_desc_valid),
        .wr_desc_ready   (wr_desc_ready),
        .rd_status       (rd_status),
        .rd_status_valid (rd_status_valid),
        .wr_status       (wr_status),
        .wr_status_valid (wr_status_valid),
        .rq_tap          (rq_tap),
        .rc_tap          (rc_tap),
        .cq_tap          (cq_tap),
        .cc_tap          (cc_tap),
        .dma_enable      (dma_enable),
        .irq             (irq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic dma_desc_t random_desc();
        dma_desc_t d;
        logic [31:0] r;
        d.pcie_addr[63:32] = next_rand();
        d.pcie_addr[31:0] = next_rand();
        d.axi_addr = next_rand();
        r = next_rand();
        d.len = r[15:0];
        d.tag = r[23:16];
        return d;
    endfunction

    // register value as the host should see it, status as {valid, 19'b0, err, tag}
    function automatic reg_data_t expected_read(input reg_addr_t addr);
        reg_data_t v;
        v = '0;
        case ({addr[15:2], 2'b00})
            `REG_ENABLE:    v[0] = enable_m;
            `REG_RD_STATUS: v = {status_valid_m[0], 19'd0, status_m[0].err, status_m[0].tag};
            `REG_WR_STATUS: v = {status_valid_m[1], 19'd0, status_m[1].err, status_m[1].tag};
            `REG_CNT_RQ:    v = count_m[0];
            `REG_CNT_RC:    v = count_m[1];
            `REG_CNT_CQ:    v = count_m[2];
            `REG_CNT_CC:    v = count_m[3];
            default:        v = '0;
        endcase
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            err_count++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
        int n;
        if (addr == `REG_ENABLE) begin
            enable_m = data[0];
        end
        wr_valid = 1'b1;
        wr_addr  = addr;
        wr_data  = data;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wr_ack && n < TIMEOUT);
        if (!wr_ack) begin
            err_count++;
            $display("timeout waiting for wr_ack on a write to %h", addr);
        end
        wr_valid = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr);
        int n;
        exp_q.push_back(expected_read(addr));
        addr_q.push_back(addr);
        // flag clears on the accepting edge
        if ({addr[15:2], 2'b00} == `REG_RD_STATUS) begin
            status_valid_m[0] = 1'b0;
        end
        if ({addr[15:2], 2'b00} == `REG_WR_STATUS) begin
            status_valid_m[1] = 1'b0;
        end
        rd_valid = 1'b1;
        rd_addr  = addr;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rd_ack && n < TIMEOUT);
        if (!rd_ack) begin
            err_count++;
            $display("timeout waiting for rd_ack on a read from %h", addr);
        end
        rd_valid = 1'b0;
    endtask

    task automatic launch_desc(input int dir, input dma_desc_t d);
        reg_addr_t off;
        off = (dir == 0) ? 16'h0000 : (`REG_WR_PCIE_LO - `REG_RD_PCIE_LO);
        write_reg(`REG_RD_PCIE_LO + off, d.pcie_addr[31:0]);
        write_reg(`REG_RD_PCIE_HI + off, d.pcie_addr[63:32]);
        write_reg(`REG_RD_AXI + off, d.axi_addr);
        write_reg(`REG_RD_LEN + off, {16'd0, d.len});
        write_reg(`REG_RD_TAG + off, {24'd0, d.tag});
    endtask

    // random ready until the engine side takes the descriptor
    task automatic drain_desc(input int dir, input dma_desc_t exp);
        logic [31:0] r;
        logic        ready;
        int          n;
        n = 0;
        ready = 1'b0;
        while (!ready && n < TIMEOUT) begin
            r = next_rand();
            ready = r[0] & r[1];
            if (dir == 0) begin
                rd_desc_ready = ready;
            end else begin
                wr_desc_ready = ready;
            end
            @(negedge clk);
            n++;
            if (dir == 0) begin
                check_value("rd_desc_valid", rd_desc_valid, !ready);
                if (!ready) begin
                    check_value("rd_desc", rd_desc, exp);
                end
            end else begin
                check_value("wr_desc_valid", wr_desc_valid, !ready);
                if (!ready) begin
                    check_value("wr_desc", wr_desc, exp);
                end
            end
        end
        if (!ready) begin
            err_count++;
            $display("timeout waiting for a ready cycle on descriptor %0d", dir);
        end
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
    endtask

    task automatic pulse_status(input int dir, input dma_status_t st);
        if (dir == 0) begin
            rd_status = st;
            rd_status_valid = 1'b1;
        end else begin
            wr_status = st;
            wr_status_valid = 1'b1;
        end
        @(posedge clk);
        check_value("irq", irq, 1'b1);
        @(negedge clk);
        rd_status_valid = 1'b0;
        wr_status_valid = 1'b0;
        status_m[dir] = st;
        status_valid_m[dir] = 1'b1;
        @(posedge clk);
        check_value("irq", irq, 1'b0);
        @(negedge clk);
    endtask

    task automatic run_taps(input int cycles);
        logic [31:0] r;
        stream_tap_t t [4];
        for (int c = 0; c < cycles; c++) begin
            r = next_rand();
            for (int i = 0; i < 4; i++) begin
                t[i] = stream_tap_t'(r[3*i +: 3]);
                if (t[i].valid && t[i].ready && t[i].last) begin
                    count_m[i] = count_m[i] + 32'd1;
                end
            end
            rq_tap = t[0];
            rc_tap = t[1];
            cq_tap = t[2];
            cc_tap = t[3];
            @(negedge clk);
        end
        rq_tap = '0;
        rc_tap = '0;
        cq_tap = '0;
        cc_tap = '0;
        @(negedge clk);
    endtask

    // every read acknowledge is matched against the model
    always @(negedge clk) begin : compare_rd
        reg_data_t exp;
        reg_addr_t addr;
        if (rd_ack) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("rd_ack arrived at %0t without a pending read", $time);
            end else begin
                exp = exp_q.pop_front();
                addr = addr_q.pop_front();
                if (rd_data !== exp) begin
                    err_count++;
                    $display("error at %0t: rd_data from %h got %h expected %h",
                             $time, addr, rd_data, exp);
                end
            end
        end
    end

    initial begin
        dma_desc_t   d0;
        dma_desc_t   d1;
        dma_status_t st;
        logic [31:0] r;
        int          n;

        rng = 32'h371a_331c;
        err_count = 0;
        wr_valid = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        rd_valid = 1'b0;
        rd_addr = '0;
        rd_desc_ready = 1'b0;
        wr_desc_ready = 1'b0;
        rd_status = '0;
        rd_status_valid = 1'b0;
        wr_status = '0;
        wr_status_valid = 1'b0;
        rq_tap = '0;
        rc_tap = '0;
        cq_tap = '0;
        cc_tap = '0;
        enable_m = 1'b0;
        status_m[0] = '0;
        status_m[1] = '0;
        status_valid_m = '0;
        for (int i = 0; i < 4; i++) begin
            count_m[i] = '0;
        end

        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (rst && n < TIMEOUT);
        if (rst) begin
            err_count++;
            $display("timeout waiting for reset release");
        end
        @(negedge clk);

        // idle after reset
        check_value("wr_ack", wr_ack, 1'b0);
        check_value("rd_ack", rd_ack, 1'b0);
        check_value("rd_desc_valid", rd_desc_valid, 1'b0);
        check_value("wr_desc_valid", wr_desc_valid, 1'b0);
        check_value("dma_enable", dma_enable, 1'b0);
        check_value("irq", irq, 1'b0);
        foreach (REG_LIST[i]) begin
            read_reg(REG_LIST[i]);
        end

        write_reg(`REG_ENABLE, 32'd1);
        read_reg(`REG_ENABLE);
        check_value("dma_enable", dma_enable, 1'b1);
        write_reg(`REG_ENABLE, 32'd0);
        read_reg(`REG_ENABLE);
        check_value("dma_enable", dma_enable, 1'b0);

        d0 = random_desc();
        launch_desc(0, d0);
        check_value("rd_desc_valid", rd_desc_valid, 1'b1);
        check_value("rd_desc", rd_desc, d0);
        check_value("wr_desc_valid", wr_desc_valid, 1'b0);
        drain_desc(0, d0);

        // both directions pending, each ready retires only its own
        d1 = random_desc();
        launch_desc(1, d1);
        check_value("wr_desc_valid", wr_desc_valid, 1'b1);
        check_value("wr_desc", wr_desc, d1);
        d0 = random_desc();
        launch_desc(0, d0);
        rd_desc_ready = 1'b1;
        @(negedge clk);
        rd_desc_ready = 1'b0;
        check_value("rd_desc_valid", rd_desc_valid, 1'b0);
        check_value("wr_desc_valid", wr_desc_valid, 1'b1);
        check_value("wr_desc", wr_desc, d1);
        d0 = random_desc();
        launch_desc(0, d0);
        drain_desc(1, d1);
        check_value("rd_desc_valid", rd_desc_valid, 1'b1);
        check_value("rd_desc", rd_desc, d0);
        drain_desc(0, d0);

        for (int dir = 0; dir < 2; dir++) begin
            r = next_rand();
            st.tag = r[7:0];
            st.err = r[11:8];
            pulse_status(dir, st);
            read_reg(dir == 0 ? `REG_RD_STATUS : `REG_WR_STATUS);
            read_reg(dir == 0 ? `REG_RD_STATUS : `REG_WR_STATUS);
            read_reg(dir == 0 ? `REG_WR_STATUS : `REG_RD_STATUS);
        end

        run_taps(200);
        read_reg(`REG_CNT_RQ);
        read_reg(`REG_CNT_RC);
        read_reg(`REG_CNT_CQ);
        read_reg(`REG_CNT_CC);
        read_reg(16'h0300);
        read_reg(16'h010C);

        @(negedge clk);
        if (exp_q.size() != 0) begin
            err_count++;
            $display("%0d reads never got a response", exp_q.size());
        end
        $display("errors: %0d", err_count);
        if (err_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset covers two rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* pcie_dma_ctrl_assertions.sv */
// concurrent checks on acknowledge pulses, descriptor handshake and reset state
`timescale 1ns/1ps

module pcie_dma_ctrl_assertions (
    input logic                         clk,
    input logic                         rst,
    input logic                         wr_ack,
    input logic                         rd_ack,
    input pcie_dma_ctrl_pkg::dma_desc_t rd_desc,
    input logic                         rd_desc_valid,
    input logic                         rd_desc_ready,
    input pcie_dma_ctrl_pkg::dma_desc_t wr_desc,
    input logic                         wr_desc_valid,
    input logic                         wr_desc_ready,
    input logic                         dma_enable
);

    ack_single_wr: assert property (@(posedge clk) disable iff (rst) wr_ack |=> !wr_ack)
        else $error("wr_ack stayed high for two cycles");

    ack_single_rd: assert property (@(posedge clk) disable iff (rst) rd_ack |=> !rd_ack)
        else $error("rd_ack stayed high for two cycles");

    // descriptor held while the engine stalls
    rd_desc_hold: assert property (@(posedge clk) disable iff (rst)
        rd_desc_valid && !rd_desc_ready |=> rd_desc_valid && $stable(rd_desc))
        else $error("rd_desc changed or dropped without rd_desc_ready");

    wr_desc_hold: assert property (@(posedge clk) disable iff (rst)
        wr_desc_valid && !wr_desc_ready |=> wr_desc_valid && $stable(wr_desc))
        else $error("wr_desc changed or dropped without wr_desc_ready");

    reset_state: assert property (@(posedge clk) $fell(rst) |->
        !wr_ack && !rd_ack && !rd_desc_valid && !wr_desc_valid && !dma_enable)
        else $error("control outputs active in the first cycle after reset");

endmodule

bind pcie_dma_ctrl_top pcie_dma_ctrl_assertions asrt0 (
    .clk           (clk),
    .rst           (rst),
    .wr_ack        (wr_ack),
    .rd_ack        (rd_ack),
    .rd_desc       (rd_desc),
    .rd_desc_valid (rd_desc_valid),
    .rd_desc_ready (rd_desc_ready),
    .wr_desc       (wr_desc),
    .wr_desc_valid (wr_desc_valid),
    .wr_desc_ready (wr_desc_ready),
    .dma_enable    (dma_enable)
);

/* pcie_dma_ctrl_top.sv */
// top level joining bus front end, descriptor registers and packet counters
`timescale 1ns/1ps

module pcie_dma_ctrl_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_valid,
    input  pcie_dma_ctrl_pkg::reg_addr_t   wr_addr,
    input  pcie_dma_ctrl_pkg::reg_data_t   wr_data,
    output logic                           wr_ack,
    input  logic                           rd_valid,
    input  pcie_dma_ctrl_pkg::reg_addr_t   rd_addr,
    output pcie_dma_ctrl_pkg::reg_data_t   rd_data,
    output logic                           rd_ack,
    output pcie_dma_ctrl_pkg::dma_desc_t   rd_desc,
    output logic                           rd_desc_valid,
    input  logic                           rd_desc_ready,
    output pcie_dma_ctrl_pkg::dma_desc_t   wr_desc,
    output logic                           wr_desc_valid,
    input  logic                           wr_desc_ready,
    input  pcie_dma_ctrl_pkg::dma_status_t rd_status,
    input  logic                           rd_status_valid,
    input  pcie_dma_ctrl_pkg::dma_status_t wr_status,
    input  logic                           wr_status_valid,
    input  pcie_dma_ctrl_pkg::stream_tap_t rq_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t rc_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t cq_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t cc_tap,
    output logic                           dma_enable,
    output logic                           irq
);
    import pcie_dma_ctrl_pkg::*;

    reg_sel_t     sel;
    logic         wr_en;
    logic         rd_en;
    reg_data_t    wdata;
    desc_rdback_t rdback;
    tlp_counts_t  counts;

    ctrl_reg_bus bus0 (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_valid (rd_valid),
        .rd_addr  (rd_addr),
        .rdback   (rdback),
        .counts   (counts),
        .wr_ack   (wr_ack),
        .rd_ack   (rd_ack),
        .rd_data  (rd_data),
        .sel      (sel),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .wdata    (wdata)
    );

    dma_desc_regs regs0 (
        .clk             (clk),
        .rst             (rst),
        .sel             (sel),
        .wr_en           (wr_en),
        .rd_en           (rd_en),
        .wdata           (wdata),
        .rd_desc_ready   (rd_desc_ready),
        .wr_desc_ready   (wr_desc_ready),
        .rd_status       (rd_status),
        .rd_status_valid (rd_status_valid),
        .wr_status       (wr_status),
        .wr_status_valid (wr_status_valid),
        .rd_desc         (rd_desc),
        .rd_desc_valid   (rd_desc_valid),
        .wr_desc         (wr_desc),
        .wr_desc_valid   (wr_desc_valid),
        .rdback          (rdback),
        .dma_enable      (dma_enable),
        .irq             (irq)
    );

    tlp_counters cnt0 (
        .clk    (clk),
        .rst    (rst),
        .rq_tap (rq_tap),
        .rc_tap (rc_tap),
        .cq_tap (cq_tap),
        .cc_tap (cc_tap),
        .counts (counts)
    );

endmodule

/* ctrl_reg_bus.sv */
// register bus front end with address decode, acknowledge and read mux
`timescale 1ns/1ps
`include "pcie_dma_ctrl_consts.svh"

module ctrl_reg_bus (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            wr_valid,
    input  pcie_dma_ctrl_pkg::reg_addr_t    wr_addr,
    input  pcie_dma_ctrl_pkg::reg_data_t    wr_data,
    input  logic                            rd_valid,
    input  pcie_dma_ctrl_pkg::reg_addr_t    rd_addr,
    input  pcie_dma_ctrl_pkg::desc_rdback_t rdback,
    input  pcie_dma_ctrl_pkg::tlp_counts_t  counts,
    output logic                            wr_ack,
    output logic                            rd_ack,
    output pcie_dma_ctrl_pkg::reg_data_t    rd_data,
    output pcie_dma_ctrl_pkg::reg_sel_t     sel,
    output logic                            wr_en,
    output logic                            rd_en,
    output pcie_dma_ctrl_pkg::reg_data_t    wdata
);
    import pcie_dma_ctrl_pkg::*;

    reg_data_t rd_mux;

    function automatic reg_sel_t decode(reg_addr_t addr);
        case ({addr[`REG_ADDR_W-1:2], 2'b00})
            `REG_ENABLE:     return SEL_ENABLE;
            `REG_RD_PCIE_LO: return SEL_RD_PCIE_LO;
            `REG_RD_PCIE_HI: return SEL_RD_PCIE_HI;
            `REG_RD_AXI:     return SEL_RD_AXI;
            `REG_RD_LEN:     return SEL_RD_LEN;
            `REG_RD_TAG:     return SEL_RD_TAG;
            `REG_RD_STATUS:  return SEL_RD_STATUS;
            `REG_WR_PCIE_LO: return SEL_WR_PCIE_LO;
            `REG_WR_PCIE_HI: return SEL_WR_PCIE_HI;
            `REG_WR_AXI:     return SEL_WR_AXI;
            `REG_WR_LEN:     return SEL_WR_LEN;
            `REG_WR_TAG:     return SEL_WR_TAG;
            `REG_WR_STATUS:  return SEL_WR_STATUS;
            `REG_CNT_RQ:     return SEL_CNT_RQ;
            `REG_CNT_RC:     return SEL_CNT_RC;
            `REG_CNT_CQ:     return SEL_CNT_CQ;
            `REG_CNT_CC:     return SEL_CNT_CC;
            default:         return SEL_NONE;
        endcase
    endfunction

    // tag in 7:0, error in 11:8, valid flag in bit 31
    function automatic reg_data_t status_word(dma_status_t st, logic valid);
        reg_data_t w;
        w = '0;
        w[`DMA_TAG_W-1:0] = st.tag;
        w[`DMA_TAG_W+`DMA_ERR_W-1:`DMA_TAG_W] = st.err;
        w[`REG_DATA_W-1] = valid;
        return w;
    endfunction

    // a read colliding with a write waits one cycle
    assign wr_en = wr_valid && !wr_ack;
    assign rd_en = rd_valid && !rd_ack && !wr_en;
    assign sel   = wr_en ? decode(wr_addr) : (rd_en ? decode(rd_addr) : SEL_NONE);
    assign wdata = wr_data;

    always_comb begin
        case (sel)
            SEL_ENABLE:    rd_mux = {{(`REG_DATA_W-1){1'b0}}, rdback.enable};
            SEL_RD_STATUS: rd_mux = status_word(rdback.rd_status, rdback.rd_status_valid);
            SEL_WR_STATUS: rd_mux = status_word(rdback.wr_status, rdback.wr_status_valid);
            SEL_CNT_RQ:    rd_mux = counts.rq;
            SEL_CNT_RC:    rd_mux = counts.rc;
            SEL_CNT_CQ:    rd_mux = counts.cq;
            SEL_CNT_CC:    rd_mux = counts.cc;
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            wr_ack <= wr_en;
            rd_ack <= rd_en;
        end
    end

endmodule

/* tlp_counters.sv */
// end-of-packet counters on the rq, rc, cq and cc stream taps
`timescale 1ns/1ps

module tlp_counters (
    input  logic                           clk,
    input  logic                           rst,
    input  pcie_dma_ctrl_pkg::stream_tap_t rq_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t rc_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t cq_tap,
    input  pcie_dma_ctrl_pkg::stream_tap_t cc_tap,
    output pcie_dma_ctrl_pkg::tlp_counts_t counts
);
    import pcie_dma_ctrl_pkg::*;

    stream_tap_t tap [4];
    pkt_count_t  cnt_q [4];

    always_comb begin
        tap[0] = rq_tap;
        tap[1] = rc_tap;
        tap[2] = cq_tap;
        tap[3] = cc_tap;
    end

    // one count per accepted last beat, wraps
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (tap[i].valid && tap[i].ready && tap[i].last) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign counts = '{
        rq: cnt_q[0],
        rc: cnt_q[1],
        cq: cnt_q[2],
        cc: cnt_q[3]
    };

endmodule

/* dma_desc_regs.sv */
// descriptor registers, launch handshake, sticky status, enable and irq
`timescale 1ns/1ps
`include "pcie_dma_ctrl_consts.svh"

module dma_desc_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  pcie_dma_ctrl_pkg::reg_sel_t     sel,
    input  logic                            wr_en,
    input  logic                            rd_en,
    input  pcie_dma_ctrl_pkg::reg_data_t    wdata,
    input  logic                            rd_desc_ready,
    input  logic                            wr_desc_ready,
    input  pcie_dma_ctrl_pkg::dma_status_t  rd_status,
    input  logic                            rd_status_valid,
    input  pcie_dma_ctrl_pkg::dma_status_t  wr_status,
    input  logic                            wr_status_valid,
    output pcie_dma_ctrl_pkg::dma_desc_t    rd_desc,
    output logic                            rd_desc_valid,
    output pcie_dma_ctrl_pkg::dma_desc_t    wr_desc,
    output logic                            wr_desc_valid,
    output pcie_dma_ctrl_pkg::desc_rdback_t rdback,
    output logic                            dma_enable,
    output logic                            irq
);
    import pcie_dma_ctrl_pkg::*;

    // index 0 is the read direction, index 1 the write direction
    dma_desc_t   desc_q [2];
    logic [1:0]  desc_valid_q;
    dma_status_t status_q [2];
    logic [1:0]  status_valid_q;
    logic        enable_q;

    dma_status_t status_in [2];
    logic [1:0]  status_pulse;
    logic [1:0]  desc_ready;

    logic [1:0]  ld_pcie_lo;
    logic [1:0]  ld_pcie_hi;
    logic [1:0]  ld_axi;
    logic [1:0]  ld_len;
    logic [1:0]  ld_tag;
    logic [1:0]  clr_status;

    always_comb begin
        status_in[0] = rd_status;
        status_in[1] = wr_status;
        status_pulse = {wr_status_valid, rd_status_valid};
        desc_ready   = {wr_desc_ready, rd_desc_ready};

        ld_pcie_lo = {wr_en && sel == SEL_WR_PCIE_LO, wr_en && sel == SEL_RD_PCIE_LO};
        ld_pcie_hi = {wr_en && sel == SEL_WR_PCIE_HI, wr_en && sel == SEL_RD_PCIE_HI};
        ld_axi     = {wr_en && sel == SEL_WR_AXI, wr_en && sel == SEL_RD_AXI};
        ld_len     = {wr_en && sel == SEL_WR_LEN, wr_en && sel == SEL_RD_LEN};
        ld_tag     = {wr_en && sel == SEL_WR_TAG, wr_en && sel == SEL_RD_TAG};
        clr_status = {rd_en && sel == SEL_WR_STATUS, rd_en && sel == SEL_RD_STATUS};
    end

    // descriptor fields
    always_ff @(posedge clk) begin
        for (int i = 0; i < 2; i++) begin
            if (ld_pcie_lo[i]) begin
                desc_q[i].pcie_addr[`REG_DATA_W-1:0] <= wdata;
            end
            if (ld_pcie_hi[i]) begin
                desc_q[i].pcie_addr[`PCIE_ADDR_W-1:`REG_DATA_W] <= wdata;
            end
            if (ld_axi[i]) begin
                desc_q[i].axi_addr <= wdata;
            end
            if (ld_len[i]) begin
                desc_q[i].len <= wdata[`DMA_LEN_W-1:0];
            end
            if (ld_tag[i]) begin
                desc_q[i].tag <= wdata[`DMA_TAG_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable_q       <= 1'b0;
            desc_valid_q   <= '0;
            status_valid_q <= '0;
            status_q[0]    <= '0;
            status_q[1]    <= '0;
        end else begin
            if (wr_en && sel == SEL_ENABLE) begin
                enable_q <= wdata[0];
            end
            for (int i = 0; i < 2; i++) begin
                // tag write launches, own ready retires
                if (ld_tag[i]) begin
                    desc_valid_q[i] <= 1'b1;
                end else if (desc_ready[i]) begin
                    desc_valid_q[i] <= 1'b0;
                end
                // a new completion beats the read clear
                if (status_pulse[i]) begin
                    status_q[i]       <= status_in[i];
                    status_valid_q[i] <= 1'b1;
                end else if (clr_status[i]) begin
                    status_valid_q[i] <= 1'b0;
                end
            end
        end
    end

    assign rd_desc       = desc_q[0];
    assign rd_desc_valid = desc_valid_q[0];
    assign wr_desc       = desc_q[1];
    assign wr_desc_valid = desc_valid_q[1];
    assign dma_enable    = enable_q;
    assign irq           = rd_status_valid | wr_status_valid;

    assign rdback = '{
        enable:          enable_q,
        rd_status:       status_q[0],
        rd_status_valid: status_valid_q[0],
        wr_status:       status_q[1],
        wr_status_valid: status_valid_q[1]
    };

endmodule

/* pcie_dma_ctrl_pkg.sv */
// vector typedefs, descriptor and status structs, register-select enum
`include "pcie_dma_ctrl_consts.svh"

package pcie_dma_ctrl_pkg;

    typedef logic [`REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [`REG_DATA_W-1:0]  reg_data_t;
    typedef logic [`PCIE_ADDR_W-1:0] pcie_addr_t;
    typedef logic [`AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`DMA_LEN_W-1:0]   dma_len_t;
    typedef logic [`DMA_TAG_W-1:0]   dma_tag_t;
    typedef logic [`DMA_ERR_W-1:0]   dma_err_t;
    typedef logic [`CNT_W-1:0]       pkt_count_t;

    // descriptor handed to the DMA engine
    typedef struct packed {
        pcie_addr_t pcie_addr;
        axi_addr_t  axi_addr;
        dma_len_t   len;
        dma_tag_t   tag;
    } dma_desc_t;

    typedef struct packed {
        dma_tag_t tag;
        dma_err_t err;
    } dma_status_t;

    // handshake signals of one PCIe stream, observed only
    typedef struct packed {
        logic valid;
        logic ready;
        logic last;
    } stream_tap_t;

    typedef struct packed {
        pkt_count_t rq;
        pkt_count_t rc;
        pkt_count_t cq;
        pkt_count_t cc;
    } tlp_counts_t;

    typedef struct packed {
        logic        enable;
        dma_status_t rd_status;
        logic        rd_status_valid;
        dma_status_t wr_status;
        logic        wr_status_valid;
    } desc_rdback_t;

    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_ENABLE,
        SEL_RD_PCIE_LO,
        SEL_RD_PCIE_HI,
        SEL_RD_AXI,
        SEL_RD_LEN,
        SEL_RD_TAG,
        SEL_RD_STATUS,
        SEL_WR_PCIE_LO,
        SEL_WR_PCIE_HI,
        SEL_WR_AXI,
        SEL_WR_LEN,
        SEL_WR_TAG,
        SEL_WR_STATUS,
        SEL_CNT_RQ,
        SEL_CNT_RC,
        SEL_CNT_CQ,
        SEL_CNT_CC
    } reg_sel_t;

endpackage

/* pcie_dma_ctrl_consts.svh */
// register map offsets and field widths of the DMA control block
`ifndef PCIE_DMA_CTRL_CONSTS_SVH
`define PCIE_DMA_CTRL_CONSTS_SVH

`define REG_ADDR_W      16
`define REG_DATA_W      32
`define PCIE_ADDR_W     64
`define AXI_ADDR_W      32
`define DMA_LEN_W       16
`define DMA_TAG_W       8
`define DMA_ERR_W       4
`define CNT_W           32

// global control
`define REG_ENABLE      16'h0000

// read direction descriptor
`define REG_RD_PCIE_LO  16'h0100
`define REG_RD_PCIE_HI  16'h0104
`define REG_RD_AXI      16'h0108
`define REG_RD_LEN      16'h0110
`define REG_RD_TAG      16'h0114
`define REG_RD_STATUS   16'h0118

// write direction descriptor
`define REG_WR_PCIE_LO  16'h0200
`define REG_WR_PCIE_HI  16'h0204
`define REG_WR_AXI      16'h0208
`define REG_WR_LEN      16'h0210
`define REG_WR_TAG      16'h0214
`define REG_WR_STATUS   16'h0218

// packet counters
`define REG_CNT_RQ      16'h0400
`define REG_CNT_RC      16'h0404
`define REG_CNT_CQ      16'h0408
`define REG_CNT_CC      16'h040C

`endif
